/* compile.f */
common/adam_pkg.sv
common/adam_bus_if.sv
adam_fabric/adam_arbiter.sv
adam_fabric/adam_fabric.sv
rtl/adam_periph_syscfg.sv
rtl/adam_periph_timer.sv
rtl/adam_pause_ctrl.sv
rtl/adam.sv
bench/adam_checker.sv
bench/adam_tb.sv

/* Makefile */
# Verilator build and run for the adam testbench

TOP = adam_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f compile.f

# passes only if the pass line shows up in the simulation output
run: compile
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir

/* bench/adam_tb.sv */
// adam subsystem testbench
`timescale 1ns/1ns

module adam_tb;

    localparam int NO_TIMERS    = 2;
    localparam int RESET_CYCLES = 16;
    localparam int REQ_LIMIT    = 8;
    localparam int PIN_LIMIT    = 40;
    localparam int MAX_ENTRIES  = 64;

    // entry kinds
    localparam int OP_CPU   = 0;
    localparam int OP_DBG   = 1;
    localparam int OP_BOTH  = 2;
    localparam int OP_PAUSE = 3;
    localparam int OP_IRQ   = 4;
    localparam int OP_ACK   = 5;

    // how a read result is judged
    localparam int M_EXACT   = 0;
    localparam int M_NONZERO = 1;
    localparam int M_SAME    = 2;
    localparam int M_DIFF    = 3;

    // upper bits only, so no timer is reset or paused
    localparam adam_pkg::data_t CTRL_VAL = 32'h5a5a_0000;

    logic                 clk;
    logic                 rst;
    logic                 cpu_req;
    logic                 cpu_we;
    adam_pkg::addr_t      cpu_addr;
    adam_pkg::data_t      cpu_wdata;
    logic                 cpu_rvalid;
    adam_pkg::data_t      cpu_rdata;
    logic                 dbg_req;
    logic                 dbg_we;
    adam_pkg::addr_t      dbg_addr;
    adam_pkg::data_t      dbg_wdata;
    logic                 dbg_rvalid;
    adam_pkg::data_t      dbg_rdata;
    logic                 pause_req;
    logic                 pause_ack;
    logic [NO_TIMERS-1:0] irq;

    // stimulus table
    int              t_group [MAX_ENTRIES];
    int              t_op    [MAX_ENTRIES];
    logic            t_we    [MAX_ENTRIES];
    adam_pkg::addr_t t_addr  [MAX_ENTRIES];
    adam_pkg::data_t t_wdata [MAX_ENTRIES];
    adam_pkg::data_t t_exp   [MAX_ENTRIES];
    int              t_mode  [MAX_ENTRIES];
    adam_pkg::addr_t t_addr2 [MAX_ENTRIES];
    adam_pkg::data_t t_exp2  [MAX_ENTRIES];
    int              n_entries;

    int              seed;
    int              errors;
    int              cycles;
    int              cycle_limit;
    adam_pkg::data_t prev;

    adam #(
        .NO_TIMERS   (NO_TIMERS),
        .TIMER_WIDTH (32)
    ) dut (
        .clk        (clk),
        .rst        (rst),
        .cpu_req    (cpu_req),
        .cpu_we     (cpu_we),
        .cpu_addr   (cpu_addr),
        .cpu_wdata  (cpu_wdata),
        .cpu_rvalid (cpu_rvalid),
        .cpu_rdata  (cpu_rdata),
        .dbg_req    (dbg_req),
        .dbg_we     (dbg_we),
        .dbg_addr   (dbg_addr),
        .dbg_wdata  (dbg_wdata),
        .dbg_rvalid (dbg_rvalid),
        .dbg_rdata  (dbg_rdata),
        .pause_req  (pause_req),
        .pause_ack  (pause_ack),
        .irq        (irq)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout, the run did not finish within %0d cycles", cycle_limit);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    function automatic adam_pkg::addr_t timer_reg(input int idx, input adam_pkg::addr_t off);
        return adam_pkg::addr_t'(adam_pkg::TIMER_BASE + idx * adam_pkg::TIMER_STRIDE + off);
    endfunction

    function automatic void add_entry(input int group, input int op, input logic we,
                                      input adam_pkg::addr_t addr, input adam_pkg::data_t wdata,
                                      input adam_pkg::data_t exp, input int mode);
        t_group[n_entries] = group;
        t_op[n_entries]    = op;
        t_we[n_entries]    = we;
        t_addr[n_entries]  = addr;
        t_wdata[n_entries] = wdata;
        t_exp[n_entries]   = exp;
        t_mode[n_entries]  = mode;
        t_addr2[n_entries] = '0;
        t_exp2[n_entries]  = '0;
        n_entries++;
    endfunction

    // both ports read in the same cycle
    function automatic void add_pair(input int group, input adam_pkg::addr_t cpu_a,
                                     input adam_pkg::data_t cpu_e, input adam_pkg::addr_t dbg_a,
                                     input adam_pkg::data_t dbg_e);
        add_entry(group, OP_BOTH, 1'b0, cpu_a, '0, cpu_e, M_EXACT);
        t_addr2[n_entries-1] = dbg_a;
        t_exp2[n_entries-1]  = dbg_e;
    endfunction

    function automatic void build_table();
        adam_pkg::data_t cmp0;
        adam_pkg::data_t cmp1;
        adam_pkg::data_t all_acks;
        adam_pkg::data_t t1_pause;
        cmp0     = $random(seed);
        cmp1     = $random(seed);
        all_acks = (32'h1 << adam_pkg::STATUS_GLOBAL_ACK) | 32'h3;
        t1_pause = 32'h1 << (adam_pkg::CTRL_PAUSE_LSB + 1);

        add_entry(1, OP_CPU, 1'b1, timer_reg(0, adam_pkg::TIMER_CMP), cmp0, '0, M_EXACT);
        add_entry(1, OP_CPU, 1'b1, timer_reg(1, adam_pkg::TIMER_CMP), cmp1, '0, M_EXACT);
        add_entry(1, OP_DBG, 1'b1, adam_pkg::SYSCFG_CTRL, CTRL_VAL, '0, M_EXACT);
        add_entry(1, OP_CPU, 1'b0, timer_reg(0, adam_pkg::TIMER_CMP), '0, cmp0, M_EXACT);
        add_entry(1, OP_DBG, 1'b0, timer_reg(0, adam_pkg::TIMER_CMP), '0, cmp0, M_EXACT);
        add_entry(1, OP_CPU, 1'b0, timer_reg(1, adam_pkg::TIMER_CMP), '0, cmp1, M_EXACT);
        add_entry(1, OP_DBG, 1'b0, timer_reg(1, adam_pkg::TIMER_CMP), '0, cmp1, M_EXACT);
        add_entry(1, OP_CPU, 1'b0, adam_pkg::SYSCFG_CTRL, '0, CTRL_VAL, M_EXACT);
        add_entry(1, OP_DBG, 1'b0, adam_pkg::SYSCFG_CTRL, '0, CTRL_VAL, M_EXACT);

        add_pair(2, timer_reg(0, adam_pkg::TIMER_CMP), cmp0,
                 timer_reg(1, adam_pkg::TIMER_CMP), cmp1);
        add_pair(2, adam_pkg::SYSCFG_CTRL, CTRL_VAL, timer_reg(0, adam_pkg::TIMER_CMP), cmp0);
        add_pair(2, timer_reg(1, adam_pkg::TIMER_CMP), cmp1, adam_pkg::SYSCFG_CTRL, CTRL_VAL);

        add_entry(3, OP_CPU, 1'b1, timer_reg(0, adam_pkg::TIMER_CMP), 32'd20, '0, M_EXACT);
        add_entry(3, OP_CPU, 1'b1, timer_reg(0, adam_pkg::TIMER_CTRL), 32'h1, '0, M_EXACT);
        add_entry(3, OP_IRQ, 1'b0, '0, '0, 32'h1, M_EXACT);
        add_entry(3, OP_DBG, 1'b0, timer_reg(0, adam_pkg::TIMER_COUNT), '0, '0, M_NONZERO);
        add_entry(3, OP_CPU, 1'b1, timer_reg(0, adam_pkg::TIMER_IRQ_CLR), '0, '0, M_EXACT);
        add_entry(3, OP_IRQ, 1'b0, '0, '0, 32'h0, M_EXACT);
        add_entry(3, OP_DBG, 1'b0, timer_reg(1, adam_pkg::TIMER_CMP), '0, cmp1, M_EXACT);

        add_entry(4, OP_PAUSE, 1'b0, '0, 32'h1, '0, M_EXACT);
        add_entry(4, OP_ACK, 1'b0, '0, '0, 32'h1, M_EXACT);
        add_entry(4, OP_CPU, 1'b0, adam_pkg::SYSCFG_STATUS, '0, all_acks, M_EXACT);
        add_entry(4, OP_CPU, 1'b0, timer_reg(0, adam_pkg::TIMER_COUNT), '0, '0, M_NONZERO);
        add_entry(4, OP_DBG, 1'b0, timer_reg(0, adam_pkg::TIMER_COUNT), '0, '0, M_SAME);
        add_entry(4, OP_PAUSE, 1'b0, '0, 32'h0, '0, M_EXACT);
        add_entry(4, OP_ACK, 1'b0, '0, '0, 32'h0, M_EXACT);
        add_entry(4, OP_CPU, 1'b0, timer_reg(0, adam_pkg::TIMER_COUNT), '0, '0, M_DIFF);
        add_entry(4, OP_DBG, 1'b1, adam_pkg::SYSCFG_CTRL, t1_pause, '0, M_EXACT);
        add_entry(4, OP_CPU, 1'b0, adam_pkg::SYSCFG_STATUS, '0, 32'h2, M_EXACT);
        add_entry(4, OP_DBG, 1'b1, adam_pkg::SYSCFG_CTRL, '0, '0, M_EXACT);

        add_entry(5, OP_CPU, 1'b0, timer_reg(0, adam_pkg::TIMER_CTRL), '0, 32'h1, M_EXACT);
        add_entry(5, OP_CPU, 1'b1, adam_pkg::SYSCFG_CTRL, 32'h1, '0, M_EXACT);
        add_entry(5, OP_CPU, 1'b1, adam_pkg::SYSCFG_CTRL, '0, '0, M_EXACT);
        add_entry(5, OP_DBG, 1'b0, timer_reg(0, adam_pkg::TIMER_CMP), '0, '0, M_EXACT);
        add_entry(5, OP_DBG, 1'b0, timer_reg(0, adam_pkg::TIMER_CTRL), '0, '0, M_EXACT);
        add_entry(5, OP_CPU, 1'b0, timer_reg(1, adam_pkg::TIMER_CMP), '0, cmp1, M_EXACT);
        add_entry(5, OP_CPU, 1'b0, 12'hf00, '0, '0, M_EXACT);
    endfunction

    function automatic string test_name(input int group);
        case (group)
            1:       return "register readback";
            2:       return "arbitration";
            3:       return "timer interrupt";
            4:       return "pause";
            default: return "soft reset and unmapped space";
        endcase
    endfunction

    task automatic check_value(input string name, input adam_pkg::data_t exp,
                               input adam_pkg::data_t act);
        if (exp !== act) begin
            $display("FAIL %s expected %h got %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic judge_read(input string name, input int idx, input adam_pkg::data_t exp,
                              input adam_pkg::data_t got);
        case (t_mode[idx])
            M_EXACT:   check_value(name, exp, got);
            M_NONZERO: check_value({name, " nonzero"}, 32'h1, adam_pkg::data_t'(got != '0));
            M_SAME:    check_value({name, " vs previous read"}, prev, got);
            default:   check_value({name, " changed"}, 32'h1, adam_pkg::data_t'(got != prev));
        endcase
        if (!t_we[idx]) begin
            prev = got;
        end
    endtask

    task automatic run_bus(input int idx);
        logic            use_cpu;
        logic            use_dbg;
        int              cpu_hits;
        int              dbg_hits;
        int              waited;
        adam_pkg::data_t cpu_got;
        adam_pkg::data_t dbg_got;
        use_cpu  = (t_op[idx] != OP_DBG);
        use_dbg  = (t_op[idx] != OP_CPU);
        cpu_hits = 0;
        dbg_hits = 0;
        waited   = 0;
        cpu_got  = '0;
        dbg_got  = '0;
        @(posedge clk);
        #2;
        if (use_cpu) begin
            cpu_req   = 1'b1;
            cpu_we    = t_we[idx];
            cpu_addr  = t_addr[idx];
            cpu_wdata = t_wdata[idx];
        end
        if (use_dbg) begin
            dbg_req   = 1'b1;
            dbg_we    = t_we[idx];
            dbg_addr  = (t_op[idx] == OP_BOTH) ? t_addr2[idx] : t_addr[idx];
            dbg_wdata = t_wdata[idx];
        end
        @(posedge clk);
        #2;
        cpu_req = 1'b0;
        dbg_req = 1'b0;
        while (waited < REQ_LIMIT &&
               ((use_cpu && cpu_hits == 0) || (use_dbg && dbg_hits == 0))) begin
            @(negedge clk);
            waited++;
            if (cpu_rvalid) begin
                cpu_hits++;
                cpu_got = cpu_rdata;
            end
            if (dbg_rvalid) begin
                dbg_hits++;
                dbg_got = dbg_rdata;
            end
        end
        // one more cycle to catch a repeated response
        @(negedge clk);
        cpu_hits += int'(cpu_rvalid);
        dbg_hits += int'(dbg_rvalid);
        if (use_cpu && cpu_hits == 0) begin
            $display("no rvalid on the cpu port within %0d cycles", REQ_LIMIT);
            errors++;
        end else if (use_cpu) begin
            check_value("cpu_rvalid count", 32'h1, adam_pkg::data_t'(cpu_hits));
            judge_read("cpu_rdata", idx, t_exp[idx], cpu_got);
        end
        if (use_dbg && dbg_hits == 0) begin
            $display("no rvalid on the debug port within %0d cycles", REQ_LIMIT);
            errors++;
        end else if (use_dbg) begin
            check_value("dbg_rvalid count", 32'h1, adam_pkg::data_t'(dbg_hits));
            judge_read("dbg_rdata", idx, (t_op[idx] == OP_BOTH) ? t_exp2[idx] : t_exp[idx],
                       dbg_got);
        end
    endtask

    task automatic set_pause(input int idx);
        @(posedge clk);
        #2;
        pause_req = t_wdata[idx][0];
    endtask

    function automatic logic pins_match(input int idx);
        if (t_op[idx] == OP_IRQ) begin
            return irq == t_exp[idx][NO_TIMERS-1:0];
        end
        return pause_ack == t_exp[idx][0];
    endfunction

    task automatic wait_pins(input int idx);
        int waited;
        waited = 0;
        while (waited < PIN_LIMIT && !pins_match(idx)) begin
            @(negedge clk);
            waited++;
        end
        if (t_op[idx] == OP_IRQ) begin
            check_value("irq", t_exp[idx], adam_pkg::data_t'(irq));
        end else begin
            check_value("pause_ack", t_exp[idx], adam_pkg::data_t'(pause_ack));
        end
    endtask

    task automatic run_entry(input int idx);
        case (t_op[idx])
            OP_PAUSE:       set_pause(idx);
            OP_IRQ, OP_ACK: wait_pins(idx);
            default:        run_bus(idx);
        endcase
    endtask

    initial begin
        int start_errors;
        int tests;
        int tests_failed;
        rst          = 1'b1;
        cpu_req      = 1'b0;
        cpu_we       = 1'b0;
        cpu_addr     = '0;
        cpu_wdata    = '0;
        dbg_req      = 1'b0;
        dbg_we       = 1'b0;
        dbg_addr     = '0;
        dbg_wdata    = '0;
        pause_req    = 1'b0;
        seed         = 32'h704;
        errors       = 0;
        cycles       = 0;
        prev         = '0;
        n_entries    = 0;
        start_errors = 0;
        tests        = 0;
        tests_failed = 0;
        build_table();
        cycle_limit = 40 * n_entries + RESET_CYCLES;

        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst = 1'b0;

        for (int i = 0; i < n_entries; i++) begin
            if (i == 0 || t_group[i] != t_group[i-1]) begin
                start_errors = errors;
            end
            run_entry(i);
            if (i == n_entries - 1 || t_group[i+1] != t_group[i]) begin
                tests++;
                if (errors != start_errors) begin
                    tests_failed++;
                end
                $display("test %0d %s: %s", t_group[i], test_name(t_group[i]),
                         (errors == start_errors) ? "pass" : "fail");
            end
        end

        $display("%0d tests, %0d passed, %0d failed, %0d check errors, %0d assertion failures",
                 tests, tests - tests_failed, tests_failed, errors, dut.adam_checker.fails);
        if (errors == 0 && dut.adam_checker.fails == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* bench/adam_checker.sv */
// bus and pause protocol checks
`timescale 1ns/1ns

module adam_checker #(
    parameter int NO_TIMERS = 2
) (
    input logic                 clk,
    input logic                 rst,
    input logic                 cpu_req,
    input logic                 cpu_rvalid,
    input logic                 dbg_req,
    input logic                 dbg_rvalid,
    input logic                 pause_req,
    input logic                 pause_ack,
    input logic [NO_TIMERS-1:0] irq
);

    int unsigned fails = 0;
    logic        cpu_open;
    logic        dbg_open;
    logic        rst_q;

    // open from req until its rvalid
    always_ff @(posedge clk) begin
        rst_q <= rst;
        if (rst) begin
            cpu_open <= 1'b0;
            dbg_open <= 1'b0;
        end else begin
            if (cpu_req) begin
                cpu_open <= 1'b1;
            end else if (cpu_rvalid) begin
                cpu_open <= 1'b0;
            end
            if (dbg_req) begin
                dbg_open <= 1'b1;
            end else if (dbg_rvalid) begin
                dbg_open <= 1'b0;
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) cpu_rvalid |-> cpu_open)
        else begin
            $error("cpu rvalid without a preceding request");
            fails++;
        end

    assert property (@(posedge clk) disable iff (rst) dbg_rvalid |-> dbg_open)
        else begin
            $error("debug rvalid without a preceding request");
            fails++;
        end

    // ack only once the request has been up a full cycle
    assert property (@(posedge clk) disable iff (rst)
                     !(pause_req && $past(pause_req)) |-> !pause_ack)
        else begin
            $error("pause ack high while pause request is low or just raised");
            fails++;
        end

    // second reset cycle onwards
    assert property (@(posedge clk) rst && rst_q |-> irq == '0)
        else begin
            $error("irq high during reset");
            fails++;
        end

endmodule

bind adam adam_checker #(
    .NO_TIMERS (NO_TIMERS)
) adam_checker (
    .clk        (clk),
    .rst        (rst),
    .cpu_req    (cpu_req),
    .cpu_rvalid (cpu_rvalid),
    .dbg_req    (dbg_req),
    .dbg_rvalid (dbg_rvalid),
    .pause_req  (pause_req),
    .pause_ack  (pause_ack),
    .irq        (irq)
);

/* rtl/adam.sv */
// adam low-speed subsystem
`timescale 1ns/1ns

module adam #(
    parameter int NO_TIMERS   = 2,
    parameter int TIMER_WIDTH = 32
) (
    input  logic clk,
    input  logic rst,

    input  logic            cpu_req,
    input  logic            cpu_we,
    input  adam_pkg::addr_t cpu_addr,
    input  adam_pkg::data_t cpu_wdata,
    output logic            cpu_rvalid,
    output adam_pkg::data_t cpu_rdata,

    input  logic            dbg_req,
    input  logic            dbg_we,
    input  adam_pkg::addr_t dbg_addr,
    input  adam_pkg::data_t dbg_wdata,
    output logic            dbg_rvalid,
    output adam_pkg::data_t dbg_rdata,

    input  logic pause_req,
    output logic pause_ack,

    output logic [NO_TIMERS-1:0] irq
);

    adam_bus_if mst_bus   [adam_pkg::NO_MSTS] ();
    adam_bus_if syscfg_bus ();
    adam_bus_if timer_bus [NO_TIMERS] ();

    logic [NO_TIMERS-1:0] unit_rst;
    logic [NO_TIMERS-1:0] cfg_pause;
    logic [NO_TIMERS-1:0] unit_req;
    logic [NO_TIMERS-1:0] unit_ack;

    // master 0 is the cpu, master 1 the debug port
    assign mst_bus[0].req   = cpu_req;
    assign mst_bus[0].we    = cpu_we;
    assign mst_bus[0].addr  = cpu_addr;
    assign mst_bus[0].wdata = cpu_wdata;
    assign cpu_rvalid       = mst_bus[0].rvalid;
    assign cpu_rdata        = mst_bus[0].rdata;

    assign mst_bus[1].req   = dbg_req;
    assign mst_bus[1].we    = dbg_we;
    assign mst_bus[1].addr  = dbg_addr;
    assign mst_bus[1].wdata = dbg_wdata;
    assign dbg_rvalid       = mst_bus[1].rvalid;
    assign dbg_rdata        = mst_bus[1].rdata;

    adam_fabric #(
        .NO_TIMERS (NO_TIMERS)
    ) adam_fabric (
        .clk    (clk),
        .rst    (rst),
        .mst    (mst_bus),
        .syscfg (syscfg_bus),
        .timer  (timer_bus)
    );

    adam_periph_syscfg #(
        .NO_TIMERS (NO_TIMERS)
    ) adam_periph_syscfg (
        .clk        (clk),
        .rst        (rst),
        .slv        (syscfg_bus),
        .unit_rst   (unit_rst),
        .unit_pause (cfg_pause),
        .unit_ack   (unit_ack),
        .global_ack (pause_ack)
    );

    adam_pause_ctrl #(
        .NO_TIMERS (NO_TIMERS)
    ) adam_pause_ctrl (
        .clk        (clk),
        .rst        (rst),
        .global_req (pause_req),
        .global_ack (pause_ack),
        .cfg_pause  (cfg_pause),
        .unit_req   (unit_req),
        .unit_ack   (unit_ack)
    );

    for (genvar i = 0; i < NO_TIMERS; i++) begin : g_timer
        logic timer_rst;

        // soft reset on top of the global one
        assign timer_rst = rst || unit_rst[i];

        adam_periph_timer #(
            .TIMER_WIDTH (TIMER_WIDTH)
        ) adam_periph_timer (
            .clk       (clk),
            .rst       (timer_rst),
            .slv       (timer_bus[i]),
            .pause_req (unit_req[i]),
            .pause_ack (unit_ack[i]),
            .irq       (irq[i])
        );
    end

endmodule

/* rtl/adam_pause_ctrl.sv */
// pause request merge
`timescale 1ns/1ns

module adam_pause_ctrl #(
    parameter int NO_TIMERS = 2
) (
    input  logic clk,
    input  logic rst,

    input  logic global_req,
    output logic global_ack,

    input  logic [NO_TIMERS-1:0] cfg_pause,
    output logic [NO_TIMERS-1:0] unit_req,
    input  logic [NO_TIMERS-1:0] unit_ack
);

    logic ack_q;

    // global request reaches every unit
    assign unit_req = cfg_pause | {NO_TIMERS{global_req}};

    always_ff @(posedge clk) begin
        if (rst) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= global_req && (&unit_ack);
        end
    end

    // drops with the request
    assign global_ack = ack_q && global_req;

endmodule

/* rtl/adam_periph_timer.sv */
// pausable compare timer
`timescale 1ns/1ns

module adam_periph_timer #(
    parameter int TIMER_WIDTH = 32
) (
    input  logic clk,
    input  logic rst,

    adam_bus_if.slave slv,

    input  logic pause_req,
    output logic pause_ack,
    output logic irq
);

    logic [TIMER_WIDTH-1:0] count;
    logic [TIMER_WIDTH-1:0] cmp;
    logic                   en;
    logic                   ack_q;
    logic                   wr;
    logic                   running;
    adam_pkg::data_t        rd_val;

    assign wr      = slv.req && slv.we;
    assign running = en && !pause_req;

    // ack held only while the request stays up
    assign pause_ack = ack_q && pause_req;

    always_comb begin
        case (slv.addr)
            adam_pkg::TIMER_COUNT:   rd_val = adam_pkg::data_t'(count);
            adam_pkg::TIMER_CMP:     rd_val = adam_pkg::data_t'(cmp);
            adam_pkg::TIMER_CTRL:    rd_val = {31'b0, en};
            adam_pkg::TIMER_IRQ_CLR: rd_val = {31'b0, irq};
            default:                 rd_val = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            count      <= '0;
            cmp        <= '0;
            en         <= 1'b0;
            irq        <= 1'b0;
            ack_q      <= 1'b0;
            slv.rvalid <= 1'b0;
            slv.rdata  <= '0;
        end else begin
            ack_q      <= pause_req;
            slv.rvalid <= slv.req;
            slv.rdata  <= (slv.req && !slv.we) ? rd_val : '0;

            if (wr && slv.addr == adam_pkg::TIMER_COUNT) begin
                count <= slv.wdata[TIMER_WIDTH-1:0];
            end else if (running) begin
                count <= count + 1'b1;
            end
            if (wr && slv.addr == adam_pkg::TIMER_CMP) begin
                cmp <= slv.wdata[TIMER_WIDTH-1:0];
            end
            if (wr && slv.addr == adam_pkg::TIMER_CTRL) begin
                en <= slv.wdata[0];
            end

            // sticky, a new match beats a clear
            if (running && count == cmp) begin
                irq <= 1'b1;
            end else if (wr && slv.addr == adam_pkg::TIMER_IRQ_CLR) begin
                irq <= 1'b0;
            end
        end
    end

endmodule

/* rtl/adam_periph_syscfg.sv */
// system configuration registers
`timescale 1ns/1ns

module adam_periph_syscfg #(
    parameter int NO_TIMERS = 2
) (
    input  logic clk,
    input  logic rst,

    adam_bus_if.slave slv,

    output logic [NO_TIMERS-1:0] unit_rst,
    output logic [NO_TIMERS-1:0] unit_pause,
    input  logic [NO_TIMERS-1:0] unit_ack,
    input  logic                 global_ack
);

    adam_pkg::data_t ctrl;
    adam_pkg::data_t status;
    adam_pkg::data_t rd_val;
    logic            wr;

    assign wr = slv.req && slv.we;

    // soft resets and pause bits straight from ctrl
    assign unit_rst   = ctrl[NO_TIMERS-1:0];
    assign unit_pause = ctrl[adam_pkg::CTRL_PAUSE_LSB +: NO_TIMERS];

    // live acknowledges
    always_comb begin
        status = '0;
        status[NO_TIMERS-1:0] = unit_ack;
        status[adam_pkg::STATUS_GLOBAL_ACK] = global_ack;
    end

    always_comb begin
        case (slv.addr)
            adam_pkg::SYSCFG_CTRL: begin
                rd_val = ctrl;
            end
            adam_pkg::SYSCFG_STATUS: begin
                rd_val = status;
            end
            default: begin
                rd_val = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl       <= '0;
            slv.rvalid <= 1'b0;
            slv.rdata  <= '0;
        end else begin
            if (wr && slv.addr == adam_pkg::SYSCFG_CTRL) begin
                ctrl <= slv.wdata;
            end
            slv.rvalid <= slv.req;
            // writes answer with zero data
            slv.rdata  <= (slv.req && !slv.we) ? rd_val : '0;
        end
    end

endmodule

/* adam_fabric/adam_fabric.sv */
// register bus fabric
`timescale 1ns/1ns

module adam_fabric #(
    parameter int NO_TIMERS = 2
) (
    input logic clk,
    input logic rst,

    adam_bus_if.slave  mst    [adam_pkg::NO_MSTS],
    adam_bus_if.master syscfg,
    adam_bus_if.master timer  [NO_TIMERS]
);

    adam_bus_if sel_bus ();

    logic                 grant_idx;
    logic                 rsp_idx;
    adam_pkg::addr_t      region;
    adam_pkg::addr_t      offset;
    logic                 syscfg_hit;
    logic [NO_TIMERS-1:0] tmr_hit;
    logic [NO_TIMERS-1:0] tmr_rvalid;
    adam_pkg::data_t      tmr_rdata [NO_TIMERS];
    adam_pkg::data_t      tmr_merged;
    logic                 unm_rvalid;

    adam_arbiter adam_arbiter (
        .clk       (clk),
        .rst       (rst),
        .mst       (mst),
        .sel       (sel_bus),
        .grant_idx (grant_idx)
    );

    // decode against the map
    assign region     = sel_bus.addr & ~adam_pkg::OFFSET_MASK;
    assign offset     = sel_bus.addr & adam_pkg::OFFSET_MASK;
    assign syscfg_hit = (region == adam_pkg::SYSCFG_BASE);

    assign syscfg.req   = sel_bus.req && syscfg_hit;
    assign syscfg.we    = sel_bus.we;
    assign syscfg.addr  = offset;
    assign syscfg.wdata = sel_bus.wdata;

    for (genvar i = 0; i < NO_TIMERS; i++) begin : g_timer
        localparam adam_pkg::addr_t BASE =
            adam_pkg::addr_t'(adam_pkg::TIMER_BASE + i * adam_pkg::TIMER_STRIDE);

        assign tmr_hit[i]     = (region == BASE);
        assign timer[i].req   = sel_bus.req && tmr_hit[i];
        assign timer[i].we    = sel_bus.we;
        assign timer[i].addr  = offset;
        assign timer[i].wdata = sel_bus.wdata;
        assign tmr_rvalid[i]  = timer[i].rvalid;
        assign tmr_rdata[i]   = timer[i].rdata;
    end

    always_comb begin
        tmr_merged = '0;
        for (int i = 0; i < NO_TIMERS; i++) begin
            if (tmr_rvalid[i]) begin
                tmr_merged = tmr_merged | tmr_rdata[i];
            end
        end
    end

    // unmapped space answers itself, response owner follows the strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            unm_rvalid <= 1'b0;
            rsp_idx    <= 1'b0;
        end else begin
            unm_rvalid <= sel_bus.req && !syscfg_hit && !(|tmr_hit);
            rsp_idx    <= grant_idx;
        end
    end

    assign sel_bus.rvalid = syscfg.rvalid || (|tmr_rvalid) || unm_rvalid;
    assign sel_bus.rdata  = (syscfg.rvalid ? syscfg.rdata : '0) | tmr_merged;

    // steer back to the master that was granted
    for (genvar i = 0; i < adam_pkg::NO_MSTS; i++) begin : g_rsp
        assign mst[i].rvalid = sel_bus.rvalid && (rsp_idx == 1'(i));
        assign mst[i].rdata  = (rsp_idx == 1'(i)) ? sel_bus.rdata : '0;
    end

endmodule

/* adam_fabric/adam_arbiter.sv */
// round-robin bus arbiter
`timescale 1ns/1ns

module adam_arbiter (
    input  logic clk,
    input  logic rst,

    adam_bus_if.slave  mst [adam_pkg::NO_MSTS],
    adam_bus_if.master sel,

    output logic grant_idx
);

    localparam int N = adam_pkg::NO_MSTS;

    logic [N-1:0]    in_req;
    logic [N-1:0]    in_we;
    adam_pkg::addr_t in_addr   [N];
    adam_pkg::data_t in_wdata  [N];
    logic [N-1:0]    pend_vld;
    logic [N-1:0]    pend_we;
    adam_pkg::addr_t pend_addr [N];
    adam_pkg::data_t pend_wdata[N];
    logic [N-1:0]    eff_req;
    logic [N-1:0]    cur_we;
    adam_pkg::addr_t cur_addr  [N];
    adam_pkg::data_t cur_wdata [N];
    logic            last_idx;
    logic            win;
    logic            win_vld;

    for (genvar i = 0; i < N; i++) begin : g_in
        assign in_req[i]   = mst[i].req;
        assign in_we[i]    = mst[i].we;
        assign in_addr[i]  = mst[i].addr;
        assign in_wdata[i] = mst[i].wdata;

        // a slot holds the request until it wins
        assign eff_req[i]   = pend_vld[i] || in_req[i];
        assign cur_we[i]    = pend_vld[i] ? pend_we[i]    : in_we[i];
        assign cur_addr[i]  = pend_vld[i] ? pend_addr[i]  : in_addr[i];
        assign cur_wdata[i] = pend_vld[i] ? pend_wdata[i] : in_wdata[i];
    end

    // alternate when both ask
    always_comb begin
        win_vld = |eff_req;
        if (eff_req[0] && eff_req[1]) begin
            win = ~last_idx;
        end else begin
            win = eff_req[1];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pend_vld  <= '0;
            last_idx  <= 1'b1;
            sel.req   <= 1'b0;
            grant_idx <= 1'b0;
        end else begin
            for (int i = 0; i < N; i++) begin
                pend_vld[i] <= eff_req[i] && !(win_vld && win == 1'(i));
            end
            if (win_vld) begin
                last_idx <= win;
            end
            sel.req   <= win_vld;
            grant_idx <= win;
        end
    end

    // payload
    always_ff @(posedge clk) begin
        for (int i = 0; i < N; i++) begin
            pend_we[i]    <= cur_we[i];
            pend_addr[i]  <= cur_addr[i];
            pend_wdata[i] <= cur_wdata[i];
        end
        sel.we    <= cur_we[win];
        sel.addr  <= cur_addr[win];
        sel.wdata <= cur_wdata[win];
    end

endmodule

/* common/adam_bus_if.sv */
// register strobe bus
`timescale 1ns/1ns

interface adam_bus_if;

    logic            req;
    logic            we;
    adam_pkg::addr_t addr;
    adam_pkg::data_t wdata;
    logic            rvalid;
    adam_pkg::data_t rdata;

    modport master (
        output req, we, addr, wdata,
        input  rvalid, rdata
    );

    modport slave (
        input  req, we, addr, wdata,
        output rvalid, rdata
    );

endinterface

/* common/adam_pkg.sv */
// adam shared definitions
package adam_pkg;

    // bus widths
    typedef logic [11:0] addr_t;
    typedef logic [31:0] data_t;

    localparam int NO_MSTS = 2;

    // address map, one 256 byte window per slave
    localparam addr_t SYSCFG_BASE  = 12'h000;
    localparam addr_t TIMER_BASE   = 12'h100;
    localparam addr_t TIMER_STRIDE = 12'h100;
    localparam addr_t OFFSET_MASK  = 12'h0ff;

    // syscfg registers
    localparam addr_t SYSCFG_CTRL   = 12'h000;
    localparam addr_t SYSCFG_STATUS = 12'h004;

    // pause fields
    // ctrl holds soft resets from bit 0, pause bits from bit 8
    localparam int CTRL_PAUSE_LSB    = 8;
    localparam int STATUS_GLOBAL_ACK = 31;

    // timer registers
    localparam addr_t TIMER_COUNT   = 12'h000;
    localparam addr_t TIMER_CMP     = 12'h004;
    localparam addr_t TIMER_CTRL    = 12'h008;
    localparam addr_t TIMER_IRQ_CLR = 12'h00c;

endpackage
